// ==== design/mul_pkg.sv ====
/* Dadda multiplier shared definitions */
package mul_pkg;

    localparam int OPERAND_W = 32;
    localparam int HALF_W    = 16;
    localparam int QUARTER_W = 8;

    // operand as two's complement at the top, as a magnitude inside the core
    typedef logic [OPERAND_W-1:0]   operand_t;

    // low word of the product
    typedef logic [OPERAND_W-1:0]   result_t;

    typedef logic [HALF_W-1:0]      half_t;
    typedef logic [QUARTER_W-1:0]   quarter_t;

    // full-width products of the 8x8 and 16x16 units
    typedef logic [2*QUARTER_W-1:0] prod16_t;
    typedef logic [2*HALF_W-1:0]    prod32_t;

    // full adder cell, sum output
    function automatic logic fa_sum(input logic a, input logic b, input logic c);
        return a ^ b ^ c;
    endfunction

    // full adder cell, carry output
    function automatic logic fa_carry(input logic a, input logic b, input logic c);
        return (a & b) | (a & c) | (b & c);
    endfunction

    // half adder cell
    function automatic logic ha_sum(input logic a, input logic b);
        return a ^ b;
    endfunction

    function automatic logic ha_carry(input logic a, input logic b);
        return a & b;
    endfunction

endpackage

// ==== design/dadda_8x8.sv ====
/* Unsigned 8x8 Dadda multiplier */
`timescale 1ns/1ns

module dadda_8x8 (
    input  mul_pkg::quarter_t a_i,
    input  mul_pkg::quarter_t b_i,
    output mul_pkg::prod16_t  p_o
);

    // dot[r][c] carries weight r + c, row r is one bit of b
    logic [mul_pkg::QUARTER_W-1:0] dot [mul_pkg::QUARTER_W];

    logic [5:0]  s1, c1;
    logic [13:0] s2, c2;
    logic [9:0]  s3, c3;
    logic [11:0] s4, c4;
    logic [12:0] c5;

    always_comb begin
        for (int r = 0; r < mul_pkg::QUARTER_W; r++) begin
            dot[r] = a_i & {mul_pkg::QUARTER_W{b_i[r]}};
        end
    end

    // height 8 to 6, columns 6 to 9
    assign s1[0] = mul_pkg::ha_sum(dot[6][0], dot[5][1]);
    assign c1[0] = mul_pkg::ha_carry(dot[6][0], dot[5][1]);
    assign s1[1] = mul_pkg::fa_sum(dot[7][0], dot[6][1], dot[5][2]);
    assign c1[1] = mul_pkg::fa_carry(dot[7][0], dot[6][1], dot[5][2]);
    assign s1[2] = mul_pkg::ha_sum(dot[4][3], dot[3][4]);
    assign c1[2] = mul_pkg::ha_carry(dot[4][3], dot[3][4]);
    assign s1[3] = mul_pkg::fa_sum(dot[7][1], dot[6][2], dot[5][3]);
    assign c1[3] = mul_pkg::fa_carry(dot[7][1], dot[6][2], dot[5][3]);
    assign s1[4] = mul_pkg::ha_sum(dot[4][4], dot[3][5]);
    assign c1[4] = mul_pkg::ha_carry(dot[4][4], dot[3][5]);
    assign s1[5] = mul_pkg::fa_sum(dot[7][2], dot[6][3], dot[5][4]);
    assign c1[5] = mul_pkg::fa_carry(dot[7][2], dot[6][3], dot[5][4]);

    // height 6 to 4
    assign s2[0]  = mul_pkg::ha_sum(dot[4][0], dot[3][1]);
    assign c2[0]  = mul_pkg::ha_carry(dot[4][0], dot[3][1]);
    assign s2[1]  = mul_pkg::fa_sum(dot[5][0], dot[4][1], dot[3][2]);
    assign c2[1]  = mul_pkg::fa_carry(dot[5][0], dot[4][1], dot[3][2]);
    assign s2[2]  = mul_pkg::ha_sum(dot[2][3], dot[1][4]);
    assign c2[2]  = mul_pkg::ha_carry(dot[2][3], dot[1][4]);
    assign s2[3]  = mul_pkg::fa_sum(s1[0], dot[4][2], dot[3][3]);
    assign c2[3]  = mul_pkg::fa_carry(s1[0], dot[4][2], dot[3][3]);
    assign s2[4]  = mul_pkg::fa_sum(dot[2][4], dot[1][5], dot[0][6]);
    assign c2[4]  = mul_pkg::fa_carry(dot[2][4], dot[1][5], dot[0][6]);
    assign s2[5]  = mul_pkg::fa_sum(s1[1], s1[2], c1[0]);
    assign c2[5]  = mul_pkg::fa_carry(s1[1], s1[2], c1[0]);
    assign s2[6]  = mul_pkg::fa_sum(dot[2][5], dot[1][6], dot[0][7]);
    assign c2[6]  = mul_pkg::fa_carry(dot[2][5], dot[1][6], dot[0][7]);
    assign s2[7]  = mul_pkg::fa_sum(s1[3], s1[4], c1[1]);
    assign c2[7]  = mul_pkg::fa_carry(s1[3], s1[4], c1[1]);
    assign s2[8]  = mul_pkg::fa_sum(c1[2], dot[2][6], dot[1][7]);
    assign c2[8]  = mul_pkg::fa_carry(c1[2], dot[2][6], dot[1][7]);
    assign s2[9]  = mul_pkg::fa_sum(s1[5], c1[3], c1[4]);
    assign c2[9]  = mul_pkg::fa_carry(s1[5], c1[3], c1[4]);
    assign s2[10] = mul_pkg::fa_sum(dot[4][5], dot[3][6], dot[2][7]);
    assign c2[10] = mul_pkg::fa_carry(dot[4][5], dot[3][6], dot[2][7]);
    assign s2[11] = mul_pkg::fa_sum(dot[7][3], c1[5], dot[6][4]);
    assign c2[11] = mul_pkg::fa_carry(dot[7][3], c1[5], dot[6][4]);
    assign s2[12] = mul_pkg::fa_sum(dot[5][5], dot[4][6], dot[3][7]);
    assign c2[12] = mul_pkg::fa_carry(dot[5][5], dot[4][6], dot[3][7]);
    assign s2[13] = mul_pkg::fa_sum(dot[7][4], dot[6][5], dot[5][6]);
    assign c2[13] = mul_pkg::fa_carry(dot[7][4], dot[6][5], dot[5][6]);

    // height 4 to 3
    assign s3[0] = mul_pkg::ha_sum(dot[3][0], dot[2][1]);
    assign c3[0] = mul_pkg::ha_carry(dot[3][0], dot[2][1]);
    assign s3[1] = mul_pkg::fa_sum(s2[0], dot[2][2], dot[1][3]);
    assign c3[1] = mul_pkg::fa_carry(s2[0], dot[2][2], dot[1][3]);
    assign s3[2] = mul_pkg::fa_sum(s2[1], s2[2], c2[0]);
    assign c3[2] = mul_pkg::fa_carry(s2[1], s2[2], c2[0]);
    assign s3[3] = mul_pkg::fa_sum(c2[1], c2[2], s2[3]);
    assign c3[3] = mul_pkg::fa_carry(c2[1], c2[2], s2[3]);
    assign s3[4] = mul_pkg::fa_sum(c2[3], c2[4], s2[5]);
    assign c3[4] = mul_pkg::fa_carry(c2[3], c2[4], s2[5]);
    assign s3[5] = mul_pkg::fa_sum(c2[5], c2[6], s2[7]);
    assign c3[5] = mul_pkg::fa_carry(c2[5], c2[6], s2[7]);
    assign s3[6] = mul_pkg::fa_sum(c2[7], c2[8], s2[9]);
    assign c3[6] = mul_pkg::fa_carry(c2[7], c2[8], s2[9]);
    assign s3[7] = mul_pkg::fa_sum(c2[9], c2[10], s2[11]);
    assign c3[7] = mul_pkg::fa_carry(c2[9], c2[10], s2[11]);
    assign s3[8] = mul_pkg::fa_sum(c2[11], c2[12], s2[13]);
    assign c3[8] = mul_pkg::fa_carry(c2[11], c2[12], s2[13]);
    assign s3[9] = mul_pkg::fa_sum(dot[7][5], dot[6][6], dot[5][7]);
    assign c3[9] = mul_pkg::fa_carry(dot[7][5], dot[6][6], dot[5][7]);

    // height 3 to 2
    assign s4[0]  = mul_pkg::ha_sum(dot[2][0], dot[1][1]);
    assign c4[0]  = mul_pkg::ha_carry(dot[2][0], dot[1][1]);
    assign s4[1]  = mul_pkg::fa_sum(s3[0], dot[1][2], dot[0][3]);
    assign c4[1]  = mul_pkg::fa_carry(s3[0], dot[1][2], dot[0][3]);
    assign s4[2]  = mul_pkg::fa_sum(c3[0], s3[1], dot[0][4]);
    assign c4[2]  = mul_pkg::fa_carry(c3[0], s3[1], dot[0][4]);
    assign s4[3]  = mul_pkg::fa_sum(c3[1], s3[2], dot[0][5]);
    assign c4[3]  = mul_pkg::fa_carry(c3[1], s3[2], dot[0][5]);
    assign s4[4]  = mul_pkg::fa_sum(c3[2], s3[3], s2[4]);
    assign c4[4]  = mul_pkg::fa_carry(c3[2], s3[3], s2[4]);
    assign s4[5]  = mul_pkg::fa_sum(c3[3], s3[4], s2[6]);
    assign c4[5]  = mul_pkg::fa_carry(c3[3], s3[4], s2[6]);
    assign s4[6]  = mul_pkg::fa_sum(c3[4], s3[5], s2[8]);
    assign c4[6]  = mul_pkg::fa_carry(c3[4], s3[5], s2[8]);
    assign s4[7]  = mul_pkg::fa_sum(c3[5], s3[6], s2[10]);
    assign c4[7]  = mul_pkg::fa_carry(c3[5], s3[6], s2[10]);
    assign s4[8]  = mul_pkg::fa_sum(c3[6], s3[7], s2[12]);
    assign c4[8]  = mul_pkg::fa_carry(c3[6], s3[7], s2[12]);
    assign s4[9]  = mul_pkg::fa_sum(c3[7], s3[8], dot[4][7]);
    assign c4[9]  = mul_pkg::fa_carry(c3[7], s3[8], dot[4][7]);
    assign s4[10] = mul_pkg::fa_sum(c3[8], s3[9], c2[13]);
    assign c4[10] = mul_pkg::fa_carry(c3[8], s3[9], c2[13]);
    assign s4[11] = mul_pkg::fa_sum(c3[9], dot[7][6], dot[6][7]);
    assign c4[11] = mul_pkg::fa_carry(c3[9], dot[7][6], dot[6][7]);

    // final ripple, two rows into one
    assign p_o[0] = dot[0][0];
    assign p_o[1] = mul_pkg::ha_sum(dot[1][0], dot[0][1]);
    assign c5[0]  = mul_pkg::ha_carry(dot[1][0], dot[0][1]);
    assign p_o[2] = mul_pkg::fa_sum(s4[0], dot[0][2], c5[0]);
    assign c5[1]  = mul_pkg::fa_carry(s4[0], dot[0][2], c5[0]);

    for (genvar k = 3; k < 14; k++) begin : g_ripple
        assign p_o[k]  = mul_pkg::fa_sum(c4[k-3], s4[k-2], c5[k-2]);
        assign c5[k-1] = mul_pkg::fa_carry(c4[k-3], s4[k-2], c5[k-2]);
    end

    assign p_o[14] = mul_pkg::fa_sum(c4[11], dot[7][7], c5[12]);
    assign p_o[15] = mul_pkg::fa_carry(c4[11], dot[7][7], c5[12]);

endmodule

// ==== design/dadda_16x16.sv ====
/* Unsigned 16x16 multiplier from 8x8 trees */
`timescale 1ns/1ns

module dadda_16x16 (
    input  mul_pkg::half_t   a_i,
    input  mul_pkg::half_t   b_i,
    output mul_pkg::prod32_t p_o
);

    mul_pkg::prod16_t ll, lh, hl, hh;

    // top row of the carry-save stage, columns 8 to 23
    mul_pkg::half_t row0;
    mul_pkg::half_t s1, c1;
    logic [21:0]    c2;

    dadda_8x8 u_ll (
        .a_i (a_i[7:0]),
        .b_i (b_i[7:0]),
        .p_o (ll)
    );

    dadda_8x8 u_lh (
        .a_i (a_i[7:0]),
        .b_i (b_i[15:8]),
        .p_o (lh)
    );

    dadda_8x8 u_hl (
        .a_i (a_i[15:8]),
        .b_i (b_i[7:0]),
        .p_o (hl)
    );

    dadda_8x8 u_hh (
        .a_i (a_i[15:8]),
        .b_i (b_i[15:8]),
        .p_o (hh)
    );

    assign p_o[7:0] = ll[7:0];

    // high x high enters where the low x low tree ends
    assign row0 = {hh[7:0], ll[15:8]};

    for (genvar k = 0; k < 16; k++) begin : g_csa
        assign s1[k] = mul_pkg::fa_sum(row0[k], lh[k], hl[k]);
        assign c1[k] = mul_pkg::fa_carry(row0[k], lh[k], hl[k]);
    end

    assign p_o[8] = s1[0];
    assign p_o[9] = mul_pkg::ha_sum(s1[1], c1[0]);
    assign c2[0]  = mul_pkg::ha_carry(s1[1], c1[0]);

    for (genvar k = 2; k < 16; k++) begin : g_merge
        assign p_o[k+8] = mul_pkg::fa_sum(s1[k], c1[k-1], c2[k-2]);
        assign c2[k-1]  = mul_pkg::fa_carry(s1[k], c1[k-1], c2[k-2]);
    end

    assign p_o[24] = mul_pkg::fa_sum(hh[8], c1[15], c2[14]);
    assign c2[15]  = mul_pkg::fa_carry(hh[8], c1[15], c2[14]);

    // carry tail through the upper bits of high x high
    for (genvar k = 25; k < 31; k++) begin : g_tail
        assign p_o[k]  = mul_pkg::ha_sum(hh[k-16], c2[k-10]);
        assign c2[k-9] = mul_pkg::ha_carry(hh[k-16], c2[k-10]);
    end

    // the product fits in 32 bits, so the last carry is always zero
    assign p_o[31] = mul_pkg::ha_sum(hh[15], c2[21]);

endmodule

// ==== design/mul32_core.sv ====
/* Two-stage 32x32 magnitude multiplier */
`timescale 1ns/1ns

module mul32_core (
    input  logic              clk,
    input  logic              rst_n,
    input  mul_pkg::operand_t mag_a_i,
    input  mul_pkg::operand_t mag_b_i,
    output mul_pkg::result_t  mag_product_o
);

    mul_pkg::prod32_t p_ll, p_hl, p_lh;

    // stage one adds the upper half of low x low to high-a x low-b
    mul_pkg::half_t             s1_hi;
    logic [mul_pkg::HALF_W-2:0] c1;

    // pipeline register
    mul_pkg::result_t sum_q;
    mul_pkg::half_t   a_lo_q;
    mul_pkg::half_t   b_hi_q;

    // stage two adds low-a x high-b to the registered sum
    mul_pkg::half_t             s2_hi;
    logic [mul_pkg::HALF_W-2:0] c2;

    dadda_16x16 u_ll (
        .a_i (mag_a_i[15:0]),
        .b_i (mag_b_i[15:0]),
        .p_o (p_ll)
    );

    dadda_16x16 u_hl (
        .a_i (mag_a_i[31:16]),
        .b_i (mag_b_i[15:0]),
        .p_o (p_hl)
    );

    assign s1_hi[0] = mul_pkg::ha_sum(p_ll[16], p_hl[0]);
    assign c1[0]    = mul_pkg::ha_carry(p_ll[16], p_hl[0]);

    for (genvar k = 1; k < 15; k++) begin : g_stage1
        assign s1_hi[k] = mul_pkg::fa_sum(p_ll[k+16], p_hl[k], c1[k-1]);
        assign c1[k]    = mul_pkg::fa_carry(p_ll[k+16], p_hl[k], c1[k-1]);
    end

    // carry out of bit 31 is beyond the result word
    assign s1_hi[15] = mul_pkg::fa_sum(p_ll[31], p_hl[15], c1[14]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_q  <= '0;
            a_lo_q <= '0;
            b_hi_q <= '0;
        end else begin
            sum_q  <= {s1_hi, p_ll[15:0]};
            a_lo_q <= mag_a_i[15:0];
            b_hi_q <= mag_b_i[31:16];
        end
    end

    dadda_16x16 u_lh (
        .a_i (a_lo_q),
        .b_i (b_hi_q),
        .p_o (p_lh)
    );

    // only the low half of the third product lands below bit 32
    assign s2_hi[0] = mul_pkg::ha_sum(sum_q[16], p_lh[0]);
    assign c2[0]    = mul_pkg::ha_carry(sum_q[16], p_lh[0]);

    for (genvar k = 1; k < 15; k++) begin : g_stage2
        assign s2_hi[k] = mul_pkg::fa_sum(sum_q[k+16], p_lh[k], c2[k-1]);
        assign c2[k]    = mul_pkg::fa_carry(sum_q[k+16], p_lh[k], c2[k-1]);
    end

    assign s2_hi[15] = mul_pkg::fa_sum(sum_q[31], p_lh[15], c2[14]);

    assign mag_product_o = {s2_hi, sum_q[15:0]};

    // cleared registers must also zero the second-stage tree
    a_pipe_cleared: assert property (
        @(posedge clk) !rst_n |=> (sum_q == '0 && a_lo_q == '0 && b_hi_q == '0
                                   && p_lh == '0)
    ) else $error("pipeline not cleared after reset");

endmodule

// ==== design/signed_mul32.sv ====
/* Signed 32x32 multiplier, low word */
`timescale 1ns/1ns

module signed_mul32 (
    input  logic              clk,
    input  logic              rst_n,
    input  mul_pkg::operand_t a_i,
    input  mul_pkg::operand_t b_i,
    output mul_pkg::result_t  product_o
);

    mul_pkg::operand_t mag_a;
    mul_pkg::operand_t mag_b;
    mul_pkg::result_t  mag_product;

    // result sign, travels with the core pipeline register
    logic sign_q;

    // the most negative value maps onto the unsigned magnitude 2^31
    assign mag_a = a_i[mul_pkg::OPERAND_W-1] ? ~a_i + 1'b1 : a_i;
    assign mag_b = b_i[mul_pkg::OPERAND_W-1] ? ~b_i + 1'b1 : b_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sign_q <= 1'b0;
        end else begin
            sign_q <= a_i[mul_pkg::OPERAND_W-1] ^ b_i[mul_pkg::OPERAND_W-1];
        end
    end

    mul32_core u_core (
        .clk           (clk),
        .rst_n         (rst_n),
        .mag_a_i       (mag_a),
        .mag_b_i       (mag_b),
        .mag_product_o (mag_product)
    );

    assign product_o = sign_q ? ~mag_product + 1'b1 : mag_product;

    a_reset_zero: assert property (
        @(posedge clk) !rst_n |=> product_o == '0
    ) else $error("product not zero after reset");

endmodule

// ==== testbench/mul_checker.sv ====
/* Multiplier result checker */
`timescale 1ns/1ns

module mul_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  mul_pkg::operand_t a_i,
    input  mul_pkg::operand_t b_i,
    input  mul_pkg::result_t  product_i,
    output int                checks_o,
    output int                errors_o,
    output int                reset_cycles_o
);

    string             cur_name;
    string             pend_name;
    logic              pend_valid;
    mul_pkg::operand_t pend_a;
    mul_pkg::operand_t pend_b;
    mul_pkg::result_t  expected_q;
    int                test_checks;
    int                test_errors;

    // low word of the full signed 64-bit product
    function automatic mul_pkg::result_t ref_product(input logic [31:0] x,
                                                     input logic [31:0] y);
        logic signed [63:0] full;
        full = $signed({{32{x[31]}}, x}) * $signed({{32{y[31]}}, y});
        return full[31:0];
    endfunction

    initial begin
        pend_valid     = 1'b0;
        checks_o       = 0;
        errors_o       = 0;
        reset_cycles_o = 0;
        test_checks    = 0;
        test_errors    = 0;
    end

    // capture what the DUT accepts on this edge, a reset cycle expects zero
    always @(posedge clk) begin
        if (!rst_n) begin
            expected_q     <= '0;
            reset_cycles_o <= reset_cycles_o + 1;
        end else begin
            expected_q <= ref_product(a_i, b_i);
        end
        pend_a     <= a_i;
        pend_b     <= b_i;
        pend_name  <= cur_name;
        pend_valid <= 1'b1;
    end

    // product is stable mid-cycle
    always @(negedge clk) begin
        if (pend_valid) begin
            checks_o    = checks_o + 1;
            test_checks = test_checks + 1;
            if (product_i !== expected_q) begin
                errors_o    = errors_o + 1;
                test_errors = test_errors + 1;
                $display("MISMATCH %s: a %h b %h expected %h actual %h",
                         pend_name, pend_a, pend_b, expected_q, product_i);
            end
        end
    end

    task automatic start_test(input string name);
        cur_name = name;
    endtask

    task automatic end_test();
        $display("test %s: %0d compared, %0d wrong", cur_name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic print_summary();
        $display("total: %0d compared, %0d wrong, %0d reset cycles",
                 checks_o, errors_o, reset_cycles_o);
    endtask

endmodule

// ==== testbench/tb_signed_mul32.sv ====
/* Signed multiplier testbench */
`timescale 1ns/1ns

module tb_signed_mul32;

    localparam int RESET_LIMIT = 20;
    localparam int DRAIN_LIMIT = 10;

    logic              clk;
    logic              rst_n;
    mul_pkg::operand_t a;
    mul_pkg::operand_t b;
    mul_pkg::result_t  product;

    int checks;
    int errors;
    int reset_cycles;
    int seed;
    bit timed_out;

    signed_mul32 signed_mul32_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_i       (a),
        .b_i       (b),
        .product_o (product)
    );

    mul_checker checker_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .a_i            (a),
        .b_i            (b),
        .product_i      (product),
        .checks_o       (checks),
        .errors_o       (errors),
        .reset_cycles_o (reset_cycles)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one operand pair per cycle on the falling edge
    task automatic apply(input mul_pkg::operand_t x, input mul_pkg::operand_t y);
        if (timed_out) return;
        @(negedge clk);
        a = x;
        b = y;
    endtask

    task automatic hold_reset();
        int n;
        n = 0;
        rst_n = 1'b0;
        while (reset_cycles < 5 && n < RESET_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (reset_cycles < 5) begin
            $display("timeout: reset cycles were not seen by the checker");
            timed_out = 1'b1;
        end
        rst_n = 1'b1;
    endtask

    // wait until the last applied pair has been compared
    task automatic drain(input string what);
        int target;
        int n;
        if (timed_out) return;
        @(posedge clk);
        target = checks + 1;
        n = 0;
        while (checks < target && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (checks < target) begin
            $display("timeout: results of test %s did not arrive", what);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_extremes();
        mul_pkg::operand_t vals [5];
        vals[0] = 32'h0000_0000;
        vals[1] = 32'h0000_0001;
        vals[2] = 32'hFFFF_FFFF;
        vals[3] = 32'h8000_0000;
        vals[4] = 32'h7FFF_FFFF;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                apply(vals[i], vals[j]);
            end
        end
    endtask

    task automatic run_random();
        mul_pkg::operand_t x;
        mul_pkg::operand_t y;
        repeat (300) begin
            x = $random(seed);
            y = $random(seed);
            apply(x, y);
        end
    endtask

    initial begin
        seed      = 68810;
        timed_out = 1'b0;
        rst_n     = 1'b0;
        // operands held through reset have a nonzero product
        a         = 12345;
        b         = 6789;

        checker_i.start_test("reset");
        hold_reset();
        apply(0, 0);
        apply(0, 0);
        drain("reset");
        checker_i.end_test();

        // small positive operands, the first four inside one 8x8 tree
        @(negedge clk);
        checker_i.start_test("small");
        apply(3, 5);
        apply(255, 255);
        apply(7, 9);
        apply(200, 13);
        apply(32'h1234, 32'h56);
        apply(65535, 65535);
        drain("small");
        checker_i.end_test();

        @(negedge clk);
        checker_i.start_test("mixed_sign");
        apply(1234, -567);
        apply(-1000, 77);
        apply(-3, -5);
        apply(-65536, 32768);
        apply(32'h7FFF_FFFF, -2);
        apply(-123456, -654321);
        drain("mixed_sign");
        checker_i.end_test();

        @(negedge clk);
        checker_i.start_test("extremes");
        run_extremes();
        drain("extremes");
        checker_i.end_test();

        @(negedge clk);
        checker_i.start_test("random");
        run_random();
        drain("random");
        checker_i.end_test();

        checker_i.print_summary();
        if (!timed_out && errors == 0 && checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== signed_mul32.f ====
design/mul_pkg.sv
design/dadda_8x8.sv
design/dadda_16x16.sv
design/mul32_core.sv
design/signed_mul32.sv
testbench/mul_checker.sv
testbench/tb_signed_mul32.sv

// ==== Bender.yml ====
package:
  name: signed_mul32

sources:
  - design/mul_pkg.sv
  - design/dadda_8x8.sv
  - design/dadda_16x16.sv
  - design/mul32_core.sv
  - design/signed_mul32.sv
  - target: test
    files:
      - testbench/mul_checker.sv
      - testbench/tb_signed_mul32.sv
